// File: Bender.yml
package:
  name: rh11_regs

sources:
  # Shared package first
  - logic/rhPkg.sv
  - logic/rhBusIf.sv
  - logic/rhCsr.sv
  - logic/rhDataBuffer.sv
  - logic/rhTop.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/rhTop_chk.sv
      - sim/rhTb.sv

// File: all.f
logic/rhPkg.sv
logic/rhBusIf.sv
logic/rhCsr.sv
logic/rhDataBuffer.sv
logic/rhTop.sv
sim/rhTop_chk.sv
sim/rhTb.sv

// File: logic/rhBusIf.sv
`timescale 1ns/1ps
//////////////////////////////
// IO bus front end of the RH11 registers
// Decodes strobes into register selects and returns read data
//////////////////////////////

module rhBusIf
(
   input  logic                          clk,        // Clock
   input  logic                          rst,        // Async reset
   input  logic [rhPkg::addrWidth-1:0]   devADDR,    // Register word index
   input  logic                          devREAD,    // Read strobe
   input  logic                          devWRITE,   // Write strobe
   input  logic                          devLOBYTE,  // Low byte enable
   input  logic                          devHIBYTE,  // High byte enable
   input  logic [0:rhPkg::busWidth-1]    devDATAI,   // Big-endian data in
   input  logic [rhPkg::regWidth-1:0]    csr1Q,      // CS1 value
   input  logic [rhPkg::regWidth-1:0]    csr2Q,      // CS2 value
   input  logic [rhPkg::regWidth-1:0]    dbQ,        // DB head word
   output logic [rhPkg::regWidth-1:0]    wrData,     // Little-endian write data
   output logic                          loByte,     // Low lane qualifier
   output logic                          hiByte,     // High lane qualifier
   output logic                          csr1Wr,     // CS1 write select
   output logic                          csr2Wr,     // CS2 write select
   output logic                          dbWr,       // DB write select
   output logic                          dbRd,       // DB read select
   output logic [0:rhPkg::busWidth-1]    devDATAO    // Big-endian data out
);

   import rhPkg::*;

   logic [busWidth-1:0] busLe;                 // Swapped input bus
   logic [busWidth-1:0] rdReg;                 // Read data holding register
   logic [regWidth-1:0] rdMux;                 // Selected register value
   logic                selCsr1;
   logic                selCsr2;
   logic                selDb;

   //////////////////////////////
   // Bus swap
   //////////////////////////////

   // Vector assignment maps bit 0 onto the MSB
   assign busLe  = devDATAI;
   assign wrData = busLe[regWidth-1:0];        // Register sits in low 16 bits

   assign loByte = devLOBYTE;
   assign hiByte = devHIBYTE;

   //////////////////////////////
   // Address decode
   //////////////////////////////

   assign selCsr1 = (devADDR == addrWidth'(csr1Idx));
   assign selCsr2 = (devADDR == addrWidth'(csr2Idx));
   assign selDb   = (devADDR == addrWidth'(dbIdx));

   // Single cycle selects follow the strobes
   assign csr1Wr = devWRITE & selCsr1;
   assign csr2Wr = devWRITE & selCsr2;
   assign dbWr   = devWRITE & selDb;
   assign dbRd   = devREAD  & selDb;

   //////////////////////////////
   // Read return
   //////////////////////////////

   always_comb
   begin
      rdMux = '0;                              // Unmapped index reads zero
      if (selCsr1)
      begin
         rdMux = csr1Q;
      end
      else if (selCsr2)
      begin
         rdMux = csr2Q;
      end
      else if (selDb)
      begin
         rdMux = dbQ;                          // Head word before the pop
      end
   end

   // Captured at the read edge and held until the next read
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdReg <= '0;
      end
      else if (devREAD)
      begin
         rdReg <= {{(busWidth-regWidth){1'b0}}, rdMux};   // Zero extend
      end
   end

   assign devDATAO = rdReg;                    // Back to big-endian order

endmodule

// File: logic/rhCsr.sv
`timescale 1ns/1ps
//////////////////////////////
// CS1 and CS2 register block with GO, function code and data late
// Turns register writes into the clear pulses for the data buffer
//////////////////////////////

module rhCsr
(
   input  logic                          clk,        // Clock
   input  logic                          rst,        // Async reset
   input  logic                          devRESET,   // Bus device reset
   input  logic                          csr1Wr,     // CS1 write select
   input  logic                          csr2Wr,     // CS2 write select
   input  logic                          loByte,     // Low lane enable
   input  logic                          hiByte,     // High lane enable
   input  logic [rhPkg::regWidth-1:0]    wrData,     // Write data
   input  logic                          setDlt,     // Late access from DB
   input  logic                          bufIr,      // DB input ready
   input  logic                          bufOr,      // DB output ready
   output logic [rhPkg::regWidth-1:0]    csr1Q,      // CS1 readback
   output logic [rhPkg::regWidth-1:0]    csr2Q,      // CS2 readback
   output logic                          clrGo,      // Command cleared
   output logic                          clrTre,     // Error clear
   output logic                          clrAll,     // Controller clear
   output logic                          rhGO        // Command in progress
);

   import rhPkg::*;

   localparam int funcWidth = cs1FuncHi - cs1FuncLo + 1;

   logic                 go;                   // GO bit
   logic [funcWidth-1:0] func;                 // Function code
   logic                 dlt;                  // Sticky data late error
   logic                 cs1LoWr;
   logic                 cs1HiWr;
   logic                 cs2LoWr;

   //////////////////////////////
   // Lane qualified writes
   //////////////////////////////

   assign cs1LoWr = csr1Wr & loByte;           // GO and function field
   assign cs1HiWr = csr1Wr & hiByte;           // TRE
   assign cs2LoWr = csr2Wr & loByte;           // CLR

   // Clear pulses, one cycle wide like the strobes
   assign clrGo  = cs1LoWr & ~wrData[cs1Go];
   assign clrTre = cs1HiWr & wrData[cs1Tre];
   assign clrAll = (cs2LoWr & wrData[cs2Clr]) | devRESET;

   //////////////////////////////
   // CS1 state
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         func <= '0;
      end
      else if (clrAll)
      begin
         func <= '0;
      end
      else if (cs1LoWr)
      begin
         func <= wrData[cs1FuncHi:cs1FuncLo];
      end
   end

   // Error clear aborts the running command as well
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         go <= 1'b0;
      end
      else if (clrAll | clrTre)
      begin
         go <= 1'b0;
      end
      else if (cs1LoWr)
      begin
         go <= wrData[cs1Go];                  // GO clear write lands here too
      end
   end

   //////////////////////////////
   // Data late
   //////////////////////////////

   // Set at the edge of the late strobe, clear wins
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dlt <= 1'b0;
      end
      else if (clrAll | clrTre)
      begin
         dlt <= 1'b0;
      end
      else if (setDlt)
      begin
         dlt <= 1'b1;
      end
   end

   //////////////////////////////
   // Readback
   //////////////////////////////

   always_comb
   begin
      csr1Q                      = '0;
      csr1Q[cs1Go]               = go;
      csr1Q[cs1FuncHi:cs1FuncLo] = func;
      csr1Q[cs1Tre]              = dlt;         // Error summary
   end

   // CLR always reads back as zero
   always_comb
   begin
      csr2Q         = '0;
      csr2Q[cs2Dlt] = dlt;
      csr2Q[cs2Or]  = bufOr;
      csr2Q[cs2Ir]  = bufIr;
   end

   assign rhGO = go;

endmodule

// File: logic/rhDataBuffer.sv
`timescale 1ns/1ps
//////////////////////////////
// DB register built as a circular FIFO of 16-bit words
// Reports IR and OR and flags late reads and writes
//////////////////////////////

module rhDataBuffer
#(
   parameter int bufDepth = 66                       // Words at full
)
(
   input  logic                          clk,        // Clock
   input  logic                          rst,        // Async reset
   input  logic                          dbWr,       // DB write strobe
   input  logic                          dbRd,       // DB read strobe
   input  logic [rhPkg::regWidth-1:0]    wrData,     // Word to push
   input  logic                          clrGo,      // Flush on GO clear
   input  logic                          clrTre,     // Flush on error clear
   input  logic                          clrAll,     // Flush on controller clear
   output logic [rhPkg::regWidth-1:0]    dbQ,        // Head word
   output logic                          bufIr,      // Room for a word
   output logic                          bufOr,      // Word available
   output logic                          setDlt      // Late access
);

   import rhPkg::*;

   //////////////////////////////
   // Sizing
   //////////////////////////////

   localparam int ptrWidth = $clog2(bufDepth);       // Pointer wraps naturally
   localparam int memDepth = 1 << ptrWidth;          // Power of two storage
   localparam int cntWidth = $clog2(bufDepth + 1);   // Holds 0 to bufDepth

   logic [regWidth-1:0] mem [memDepth];              // Dual port storage
   logic [ptrWidth-1:0] wrPtr;
   logic [ptrWidth-1:0] rdPtr;
   logic [cntWidth-1:0] depth;                       // Words stored
   logic                wrD;                         // Delayed write strobe
   logic                rdD;                         // Delayed read strobe
   logic                wrOk;
   logic                rdOk;
   logic                flush;
   logic                empty;
   logic                full;

   assign empty = (depth == '0);
   assign full  = (depth == cntWidth'(bufDepth));
   assign flush = clrGo | clrTre | clrAll;

   //////////////////////////////
   // Delayed strobes
   //////////////////////////////

   // State moves one cycle after the access
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrD <= 1'b0;
         rdD <= 1'b0;
      end
      else
      begin
         wrD <= dbWr;
         rdD <= dbRd;
      end
   end

   // Late accesses do not move the state
   assign wrOk = wrD & ~full;
   assign rdOk = rdD & ~empty;

   //////////////////////////////
   // Pointers and depth
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         depth <= '0;
      end
      else if (flush)
      begin
         wrPtr <= '0;                                // Empty the buffer
         rdPtr <= '0;
         depth <= '0;
      end
      else
      begin
         if (wrOk)
         begin
            wrPtr <= wrPtr + ptrWidth'(1);
         end
         if (rdOk)
         begin
            rdPtr <= rdPtr + ptrWidth'(1);
         end
         depth <= depth + cntWidth'(wrOk) - cntWidth'(rdOk);   // Both leave it
      end
   end

   //////////////////////////////
   // Storage and head register
   //////////////////////////////

   // Word stored at the strobe edge, dropped when full
   always_ff @(posedge clk)
   begin
      if (dbWr & ~full)
      begin
         mem[wrPtr] <= wrData;
      end
   end

   // Holds the last head while empty, so a late read sees a stale word
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dbQ <= '0;
      end
      else if (~empty)
      begin
         dbQ <= mem[rdPtr];
      end
   end

   //////////////////////////////
   // Status
   //////////////////////////////

   assign setDlt = (dbRd & empty) | (dbWr & full);   // Read empty or write full
   assign bufIr  = ~full;
   assign bufOr  = ~empty;

endmodule

// File: logic/rhPkg.sv
//////////////////////////////
// Register map, bit positions and bus widths of the RH11 register model
// Shared by the RTL and the testbench through import
//////////////////////////////

package rhPkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int busWidth  = 36;            // Device data bus, bit 0 is MSB
   localparam int regWidth  = 16;            // Register and FIFO word
   localparam int addrWidth = 4;             // Register word index

   //////////////////////////////
   // Register word indices
   //////////////////////////////

   localparam int csr1Idx = 0;               // Control and status 1
   localparam int csr2Idx = 4;               // Control and status 2
   localparam int dbIdx   = 9;               // Data buffer

   //////////////////////////////
   // Bit positions
   //////////////////////////////

   // CS1
   localparam int cs1Go     = 0;             // Command go
   localparam int cs1FuncLo = 1;             // Function code low bit
   localparam int cs1FuncHi = 5;             // Function code high bit
   localparam int cs1Tre    = 14;            // Transfer error

   // CS2
   localparam int cs2Clr = 5;                // Controller clear, write only
   localparam int cs2Ir  = 6;                // Input ready
   localparam int cs2Or  = 7;                // Output ready
   localparam int cs2Dlt = 15;               // Data late

endpackage

// File: logic/rhTop.sv
`timescale 1ns/1ps
//////////////////////////////
// Register side of the RH11 controller on the IO bus
//////////////////////////////

module rhTop
#(
   parameter int bufDepth = 66                       // DB words at full
)
(
   input  logic                          clk,        // Clock
   input  logic                          rst,        // Async reset
   input  logic                          devRESET,   // Bus device reset
   input  logic [rhPkg::addrWidth-1:0]   devADDR,    // Register word index
   input  logic                          devREAD,    // Read strobe
   input  logic                          devWRITE,   // Write strobe
   input  logic                          devLOBYTE,  // Low byte enable
   input  logic                          devHIBYTE,  // High byte enable
   input  logic [0:rhPkg::busWidth-1]    devDATAI,   // Big-endian data in
   output logic [0:rhPkg::busWidth-1]    devDATAO,   // Big-endian data out
   output logic                          rhBUFIR,    // DB input ready
   output logic                          rhBUFOR,    // DB output ready
   output logic                          rhGO        // Command in progress
);

   import rhPkg::*;

   logic [regWidth-1:0] wrData;
   logic [regWidth-1:0] csr1Q;
   logic [regWidth-1:0] csr2Q;
   logic [regWidth-1:0] dbQ;
   logic                loByte;
   logic                hiByte;
   logic                csr1Wr;
   logic                csr2Wr;
   logic                dbWr;
   logic                dbRd;
   logic                clrGo;
   logic                clrTre;
   logic                clrAll;
   logic                setDlt;

   //////////////////////////////
   // Bus front end
   //////////////////////////////

   rhBusIf busIf_i
   (
      .clk       (clk),
      .rst       (rst),
      .devADDR   (devADDR),
      .devREAD   (devREAD),
      .devWRITE  (devWRITE),
      .devLOBYTE (devLOBYTE),
      .devHIBYTE (devHIBYTE),
      .devDATAI  (devDATAI),
      .csr1Q     (csr1Q),
      .csr2Q     (csr2Q),
      .dbQ       (dbQ),
      .wrData    (wrData),
      .loByte    (loByte),
      .hiByte    (hiByte),
      .csr1Wr    (csr1Wr),
      .csr2Wr    (csr2Wr),
      .dbWr      (dbWr),
      .dbRd      (dbRd),
      .devDATAO  (devDATAO)
   );

   // Control and status registers
   rhCsr csr_i
   (
      .clk      (clk),
      .rst      (rst),
      .devRESET (devRESET),
      .csr1Wr   (csr1Wr),
      .csr2Wr   (csr2Wr),
      .loByte   (loByte),
      .hiByte   (hiByte),
      .wrData   (wrData),
      .setDlt   (setDlt),
      .bufIr    (rhBUFIR),               // Status loops back into CS2
      .bufOr    (rhBUFOR),
      .csr1Q    (csr1Q),
      .csr2Q    (csr2Q),
      .clrGo    (clrGo),
      .clrTre   (clrTre),
      .clrAll   (clrAll),
      .rhGO     (rhGO)
   );

   // Data buffer FIFO
   rhDataBuffer #(.bufDepth(bufDepth)) dataBuf_i
   (
      .clk    (clk),
      .rst    (rst),
      .dbWr   (dbWr),
      .dbRd   (dbRd),
      .wrData (wrData),
      .clrGo  (clrGo),
      .clrTre (clrTre),
      .clrAll (clrAll),
      .dbQ    (dbQ),
      .bufIr  (rhBUFIR),
      .bufOr  (rhBUFOR),
      .setDlt (setDlt)
   );

endmodule

// File: sim/rhTb.sv
`timescale 1ns/1ps
//////////////////////////////
// Table driven testbench for rhTop, one bus access per row
//////////////////////////////

module rhTb;

   import rhPkg::*;

   localparam int  depthTb = 8;                    // Small FIFO to reach full
   localparam int  maxRows = 64;
   localparam bit  opRd    = 1'b0;
   localparam bit  opWr    = 1'b1;

   // Register bit values
   localparam logic [regWidth-1:0] goBit  = 16'(1 << cs1Go);
   localparam logic [regWidth-1:0] treBit = 16'(1 << cs1Tre);
   localparam logic [regWidth-1:0] clrBit = 16'(1 << cs2Clr);
   localparam logic [regWidth-1:0] irBit  = 16'(1 << cs2Ir);
   localparam logic [regWidth-1:0] orBit  = 16'(1 << cs2Or);
   localparam logic [regWidth-1:0] dltBit = 16'(1 << cs2Dlt);

   logic                   clk;
   logic                   rst;
   logic                   devRESET;
   logic [addrWidth-1:0]   devADDR;
   logic                   devREAD;
   logic                   devWRITE;
   logic                   devLOBYTE;
   logic                   devHIBYTE;
   logic [0:busWidth-1]    devDATAI;
   logic [0:busWidth-1]    devDATAO;
   logic                   rhBUFIR;
   logic                   rhBUFOR;
   logic                   rhGO;

   // Stimulus table
   bit                     opTab   [maxRows];
   logic [addrWidth-1:0]   idxTab  [maxRows];
   logic                   loTab   [maxRows];
   logic                   hiTab   [maxRows];
   logic [regWidth-1:0]    dataTab [maxRows];
   logic [regWidth-1:0]    expTab  [maxRows];
   bit                     cmpTab  [maxRows];
   int                     nRows = 0;

   logic [regWidth-1:0]    rnd [17];               // Random DB words
   integer                 seed = 51;
   int                     errors = 0;
   int                     cycles = 0;
   int                     cycleLimit = 0;

   rhTop #(.bufDepth(depthTb)) dut_i
   (
      .clk       (clk),
      .rst       (rst),
      .devRESET  (devRESET),
      .devADDR   (devADDR),
      .devREAD   (devREAD),
      .devWRITE  (devWRITE),
      .devLOBYTE (devLOBYTE),
      .devHIBYTE (devHIBYTE),
      .devDATAI  (devDATAI),
      .devDATAO  (devDATAO),
      .rhBUFIR   (rhBUFIR),
      .rhBUFOR   (rhBUFOR),
      .rhGO      (rhGO)
   );

   bind rhTop rhTop_chk chk_i
   (
      .clk(clk), .rst(rst), .rhBUFIR(rhBUFIR), .rhBUFOR(rhBUFOR), .rhGO(rhGO),
      .clrGo(clrGo), .clrTre(clrTre), .clrAll(clrAll),
      .csr2Wr(csr2Wr), .loByte(loByte), .wrData(wrData)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;                          // 40 ns period

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [regWidth-1:0] funcField(input int code);
      return 16'(code << cs1FuncLo);               // CS1 function code
   endfunction

   task automatic addWr(input int idx, input logic lo, input logic hi,
                        input logic [regWidth-1:0] data);
      opTab[nRows]   = opWr;
      idxTab[nRows]  = addrWidth'(idx);
      loTab[nRows]   = lo;
      hiTab[nRows]   = hi;
      dataTab[nRows] = data;
      expTab[nRows]  = '0;
      cmpTab[nRows]  = 1'b0;
      nRows++;
   endtask

   task automatic addRd(input int idx, input logic [regWidth-1:0] expVal, input bit cmp);
      opTab[nRows]   = opRd;
      idxTab[nRows]  = addrWidth'(idx);
      loTab[nRows]   = 1'b0;
      hiTab[nRows]   = 1'b0;
      dataTab[nRows] = '0;
      expTab[nRows]  = expVal;
      cmpTab[nRows]  = cmp;
      nRows++;
   endtask

   task automatic checkVal(input string name, input logic [busWidth-1:0] actual,
                           input logic [busWidth-1:0] expected);
      if (actual !== expected)
      begin
         errors++;
         $display("MISMATCH %s: actual %h expected %h", name, actual, expected);
      end
   endtask

   //////////////////////////////
   // Table contents
   //////////////////////////////

   task automatic buildTable();
      for (int k = 0; k < 17; k++)
      begin
         rnd[k] = 16'($random(seed));
      end
      // FIFO order
      addRd(csr2Idx, irBit, 1);                    // Empty after reset
      addWr(dbIdx, 1, 1, rnd[0]);
      addRd(csr2Idx, irBit | orBit, 1);
      addWr(dbIdx, 1, 1, rnd[1]);
      addWr(dbIdx, 1, 1, rnd[2]);
      addRd(dbIdx, rnd[0], 1);
      addRd(csr2Idx, irBit | orBit, 1);            // Still holds two
      addRd(dbIdx, rnd[1], 1);
      addRd(dbIdx, rnd[2], 1);
      addRd(csr2Idx, irBit, 1);                    // OR gone after last read
      // Fill to full
      for (int k = 0; k < depthTb; k++)
      begin
         addWr(dbIdx, 1, 1, rnd[3+k]);
      end
      addRd(csr2Idx, orBit, 1);
      addRd(dbIdx, rnd[3], 1);
      addRd(csr2Idx, irBit | orBit, 1);            // One read frees a slot
      // Late write
      addWr(dbIdx, 1, 1, rnd[11]);
      addRd(csr2Idx, orBit, 1);
      addWr(dbIdx, 1, 1, rnd[12]);                 // Dropped
      addRd(csr2Idx, dltBit | orBit, 1);
      addRd(dbIdx, rnd[4], 1);                     // Head not overwritten
      addRd(csr2Idx, dltBit | irBit | orBit, 1);
      addWr(csr1Idx, 0, 1, treBit);                // Error clear, high lane
      addRd(csr2Idx, irBit, 1);
      addRd(csr1Idx, 16'h0000, 1);
      // Late read, data is stale
      addRd(dbIdx, 16'h0000, 0);
      addRd(csr2Idx, dltBit | irBit, 1);
      addRd(csr1Idx, treBit, 1);                   // TRE mirrors DLT
      // Controller clear
      addWr(csr1Idx, 1, 0, funcField(5) | goBit);
      addWr(dbIdx, 1, 1, rnd[13]);
      addRd(csr1Idx, treBit | funcField(5) | goBit, 1);
      addRd(csr2Idx, dltBit | irBit | orBit, 1);
      addWr(csr2Idx, 1, 0, clrBit);
      addRd(csr2Idx, irBit, 1);
      addRd(csr1Idx, 16'h0000, 1);
      // Byte lanes and GO
      addWr(csr1Idx, 1, 0, treBit | funcField(3) | goBit);   // TRE lane off
      addRd(csr1Idx, funcField(3) | goBit, 1);
      addWr(csr1Idx, 0, 1, 16'h003E);              // Low lane off
      addRd(csr1Idx, funcField(3) | goBit, 1);
      addWr(dbIdx, 1, 1, rnd[14]);
      addWr(dbIdx, 1, 1, rnd[15]);
      addRd(csr2Idx, irBit | orBit, 1);
      addWr(csr1Idx, 1, 0, funcField(3));          // GO clear flushes DB
      addRd(csr1Idx, funcField(3), 1);
      addRd(csr2Idx, irBit, 1);
      addWr(dbIdx, 1, 1, rnd[16]);
      addRd(dbIdx, rnd[16], 1);                    // Pointers restart cleanly
      addRd(csr2Idx, irBit, 1);
   endtask

   //////////////////////////////
   // Row driver
   //////////////////////////////

   // Strobe for one cycle, 3 idle cycles, check read data mid cycle
   task automatic applyRow(input int i);
      @(posedge clk);
      devADDR   <= idxTab[i];
      devREAD   <= (opTab[i] == opRd);
      devWRITE  <= (opTab[i] == opWr);
      devLOBYTE <= loTab[i];
      devHIBYTE <= hiTab[i];
      devDATAI  <= {20'hA5A5A, dataTab[i]};        // Upper bits must be ignored
      @(posedge clk);
      devREAD   <= 1'b0;
      devWRITE  <= 1'b0;
      devLOBYTE <= 1'b0;
      devHIBYTE <= 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      if (opTab[i] == opRd && cmpTab[i])
      begin
         checkVal($sformatf("devDATAO row %0d", i), devDATAO, busWidth'(expTab[i]));
         if (idxTab[i] == addrWidth'(csr1Idx))
         begin
            checkVal($sformatf("rhGO row %0d", i), rhGO, busWidth'(expTab[i][cs1Go]));
         end
         // Status pins agree with CS2
         if (idxTab[i] == addrWidth'(csr2Idx))
         begin
            checkVal($sformatf("rhBUFIR row %0d", i), rhBUFIR,
                     busWidth'(expTab[i][cs2Ir]));
            checkVal($sformatf("rhBUFOR row %0d", i), rhBUFOR,
                     busWidth'(expTab[i][cs2Or]));
         end
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      rst       = 1'b1;
      devRESET  = 1'b0;
      devADDR   = '0;
      devREAD   = 1'b0;
      devWRITE  = 1'b0;
      devLOBYTE = 1'b0;
      devHIBYTE = 1'b0;
      devDATAI  = '0;
      buildTable();
      cycleLimit = (nRows * 4 + 3) * 2;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      // Reset state of the outputs
      @(negedge clk);
      checkVal("devDATAO after reset", devDATAO, '0);
      checkVal("rhGO after reset", rhGO, '0);
      checkVal("rhBUFIR after reset", rhBUFIR, busWidth'(1));
      checkVal("rhBUFOR after reset", rhBUFOR, '0);
      for (int i = 0; i < nRows; i++)
      begin
         applyRow(i);
      end
      repeat (2) @(posedge clk);
      $display("Errors: %0d mismatches, %0d assertion failures", errors,
               dut_i.chk_i.failCount);
      if (errors == 0 && dut_i.chk_i.failCount == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

   // Cycle limit from table length
   initial
   begin
      wait (cycleLimit > 0);
      while (cycles < cycleLimit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Errors: %0d mismatches, %0d assertion failures", errors,
               dut_i.chk_i.failCount);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: sim/rhTop_chk.sv
`timescale 1ns/1ps
//////////////////////////////
// Concurrent checks on rhTop status and clear behaviour, bound into the DUT
//////////////////////////////

module rhTop_chk
(
   input logic                         clk,
   input logic                         rst,
   input logic                         rhBUFIR,   // DB input ready
   input logic                         rhBUFOR,   // DB output ready
   input logic                         rhGO,      // Command in progress
   input logic                         clrGo,     // Clear pulses
   input logic                         clrTre,
   input logic                         clrAll,
   input logic                         csr2Wr,    // CS2 write select
   input logic                         loByte,    // Low lane enable
   input logic [rhPkg::regWidth-1:0]   wrData     // Write data
);

   import rhPkg::*;

   int failCount = 0;                              // Failed assertion count

   // Buffer can never be full and empty at once
   statusLive: assert property (@(posedge clk) disable iff (rst) rhBUFIR | rhBUFOR)
   else
   begin
      failCount++;
      $error("IR and OR are both low");
   end

   // Any clear drops the command
   goCleared: assert property (@(posedge clk) disable iff (rst)
      (clrGo | clrTre | clrAll) |=> !rhGO)
   else
   begin
      failCount++;
      $error("GO still set after a clear pulse");
   end

   // Controller clear empties the buffer quickly
   clrFlush: assert property (@(posedge clk) disable iff (rst)
      (csr2Wr & loByte & wrData[cs2Clr]) |-> ##[1:2] !rhBUFOR)
   else
   begin
      failCount++;
      $error("OR still set two cycles after CS2 CLR");
   end

endmodule
